// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module udp_rx_tile_tb \
		-f verilog.f -Mdir obj_dir -o udp_rx_tile_tb
	./obj_dir/udp_rx_tile_tb | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk; // 4 ns period.
    end
endmodule

// ==== bench/udp_rx_tile_properties.sv ====
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module udp_rx_tile_properties (
    input  logic                        clk,
    input  logic                        rst,
    input  udp_rx_pkg::noc_out_state_e  state,
    input  udp_rx_pkg::credit_cnt_t     credit_cnt,
    input  logic                        noc_val
);
    // returned credits can never push the count past what the NoC granted.
    credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= `NOC_CREDITS
    ) else $error("credit count went above the number granted at reset");

    no_send_without_credit: assert property (
        @(posedge clk) disable iff (rst)
        !(noc_val && (credit_cnt == '0))
    ) else $error("a flit was sent while no credit was left");

    // the state machine comes out of reset idle.
    idle_after_reset: assert property (
        @(posedge clk)
        rst |=> (state == udp_rx_pkg::IDLE)
    ) else $error("state machine was not idle one cycle after reset");
endmodule

// ==== bench/udp_rx_tile_tb.sv ====
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module udp_rx_tile_tb;
    localparam int NUM_PKTS     = 60;
    localparam int TBL_USED     = 6;
    localparam int SRC_X        = 2;
    localparam int SRC_Y        = 3;
    localparam int WATCHDOG_NS  = NUM_PKTS * 200 * 4;
    localparam int DRAIN_CYCLES = 200;

    logic                   clk;
    logic                   rst;
    logic                   in_hdr_val;
    logic                   in_hdr_rdy;
    udp_rx_pkg::ip_addr_t   in_src_ip;
    udp_rx_pkg::ip_addr_t   in_dst_ip;
    udp_rx_pkg::udp_port_t  in_src_port;
    udp_rx_pkg::udp_port_t  in_dst_port;
    udp_rx_pkg::udp_len_t   in_length;
    udp_rx_pkg::timestamp_t in_timestamp;
    logic                   in_data_val;
    logic                   in_data_rdy;
    udp_rx_pkg::noc_flit_t  in_data;
    logic                   in_last;
    udp_rx_pkg::padbytes_t  in_padbytes;
    logic                   cfg_wr_en;
    logic [`CAM_IDX_W-1:0]  cfg_wr_idx;
    udp_rx_pkg::udp_port_t  cfg_wr_port;
    udp_rx_pkg::xy_coord_t  cfg_wr_x;
    udp_rx_pkg::xy_coord_t  cfg_wr_y;
    udp_rx_pkg::fbits_t     cfg_wr_fbits;
    logic                   noc_val;
    udp_rx_pkg::noc_flit_t  noc_data;
    logic                   noc_credit;

    integer                 seed = 32'hadd38259;
    int unsigned            cycle_cnt = 0;
    udp_rx_pkg::noc_flit_t  exp_q [$];
    int unsigned            credit_due_q [$]; // one entry per flit not yet returned.
    udp_rx_pkg::udp_port_t  tbl_port  [TBL_USED];
    udp_rx_pkg::xy_coord_t  tbl_x     [TBL_USED];
    udp_rx_pkg::xy_coord_t  tbl_y     [TBL_USED];
    udp_rx_pkg::fbits_t     tbl_fbits [TBL_USED];

    clk_gen u_clk_gen (.clk(clk));

    udp_rx_tile #(.SRC_X(SRC_X), .SRC_Y(SRC_Y)) u_udp_rx_tile (.*);

    bind udp_rx_noc_out_ctrl udp_rx_tile_properties u_properties (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .credit_cnt (credit_cnt),
        .noc_val    (noc_val)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic int find_entry(input udp_rx_pkg::udp_port_t port);
        for (int i = 0; i < TBL_USED; i++) begin
            if (tbl_port[i] == port) begin
                return i; // first entry wins, like the hardware table.
            end
        end
        return -1;
    endfunction

    task automatic idle_gap();
        repeat ({$random(seed)} % 3) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ready only depends on registers, so mid-cycle is a safe place to look.
    task automatic wait_transfer(input bit is_hdr);
        bit taken;
        do begin
            @(negedge clk);
            taken = is_hdr ? in_hdr_rdy : in_data_rdy;
            @(posedge clk);
            #1;
        end while (!taken);
    endtask

    task automatic write_table();
        for (int i = 0; i < TBL_USED; i++) begin
            tbl_port[i]  = udp_rx_pkg::udp_port_t'($random(seed));
            tbl_x[i]     = udp_rx_pkg::xy_coord_t'($random(seed));
            tbl_y[i]     = udp_rx_pkg::xy_coord_t'($random(seed));
            tbl_fbits[i] = udp_rx_pkg::fbits_t'($random(seed));
            cfg_wr_en    = 1'b1;
            cfg_wr_idx   = i[`CAM_IDX_W-1:0];
            cfg_wr_port  = tbl_port[i];
            cfg_wr_x     = tbl_x[i];
            cfg_wr_y     = tbl_y[i];
            cfg_wr_fbits = tbl_fbits[i];
            @(posedge clk);
            #1;
        end
        cfg_wr_en = 1'b0;
    endtask

    task automatic send_packet(input int p);
        udp_rx_pkg::udp_port_t  port;
        udp_rx_pkg::noc_flit_t  beat;
        udp_rx_pkg::noc_flit_t  beats [$];
        int                     data_len;
        int                     nbeats;
        int                     pad;
        int                     hit;

        port = tbl_port[{$random(seed)} % TBL_USED];
        if ((p % 10 == 5) || (({$random(seed)} % 4) == 0)) begin
            do begin
                port = udp_rx_pkg::udp_port_t'($random(seed));
            end while (find_entry(port) >= 0);
        end
        data_len = (p % 10 == 0) ? 0 : {$random(seed)} % 73; // every tenth is header only.
        nbeats   = (data_len + 15) / 16;
        pad      = nbeats * 16 - data_len;
        hit      = find_entry(port);

        in_src_ip    = udp_rx_pkg::ip_addr_t'($random(seed));
        in_dst_ip    = udp_rx_pkg::ip_addr_t'($random(seed));
        in_src_port  = udp_rx_pkg::udp_port_t'($random(seed));
        in_dst_port  = port;
        in_length    = udp_rx_pkg::udp_len_t'(data_len + `UDP_HDR_BYTES);
        in_timestamp = udp_rx_pkg::timestamp_t'($random(seed));
        for (int b = 0; b < nbeats; b++) begin
            for (int k = 0; k < 4; k++) begin
                beat[k*32 +: 32] = $random(seed);
            end
            beats.push_back(beat);
        end

        if (hit >= 0) begin
            exp_q.push_back({64'h0, tbl_x[hit], tbl_y[hit], tbl_fbits[hit],
                             udp_rx_pkg::msg_len_t'(nbeats + 1),
                             udp_rx_pkg::xy_coord_t'(SRC_X), udp_rx_pkg::xy_coord_t'(SRC_Y),
                             `PKT_IF_FBITS, 8'd1, `UDP_RX_SEGMENT});
            exp_q.push_back({in_src_ip, in_dst_ip, in_src_port, port,
                             udp_rx_pkg::udp_len_t'(data_len), in_timestamp});
            for (int b = 0; b < nbeats; b++) begin
                beat = beats[b];
                if (b == nbeats - 1) begin
                    for (int k = 0; k < pad; k++) begin
                        beat[k*8 +: 8] = 8'h00; // unused bytes sit at the low end.
                    end
                end
                exp_q.push_back(beat);
            end
        end

        idle_gap();
        in_hdr_val = 1'b1;
        wait_transfer(1'b1);
        in_hdr_val = 1'b0;
        for (int b = 0; b < nbeats; b++) begin
            idle_gap();
            in_data_val = 1'b1;
            in_data     = beats[b];
            in_last     = (b == nbeats - 1);
            in_padbytes = in_last ? udp_rx_pkg::padbytes_t'(pad) : '0;
            wait_transfer(1'b0);
            in_data_val = 1'b0;
            in_last     = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(negedge clk) begin
        if (!rst && noc_val) begin
            assert (exp_q.size() > 0)
                else abort_run("a flit left the tile while no flit was expected");
            assert (noc_data == exp_q[0])
                else abort_run($sformatf("ERR %0t: flit %h, expected %h",
                                         $time, noc_data, exp_q[0]));
            void'(exp_q.pop_front());
            assert (credit_due_q.size() < `NOC_CREDITS)
                else abort_run("more flits were outstanding than the NoC has credits");
            credit_due_q.push_back(cycle_cnt + 1 + {$random(seed)} % 6);
        end
    end

    always @(posedge clk) begin
        #1;
        noc_credit = 1'b0;
        if ((credit_due_q.size() > 0) && (credit_due_q[0] <= cycle_cnt)) begin
            noc_credit = 1'b1;
            void'(credit_due_q.pop_front());
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("the run timed out before all expected flits arrived");
    end

    initial begin : stimulus
        rst          = 1'b1;
        in_hdr_val   = 1'b0;
        in_src_ip    = '0;
        in_dst_ip    = '0;
        in_src_port  = '0;
        in_dst_port  = '0;
        in_length    = '0;
        in_timestamp = '0;
        in_data_val  = 1'b0;
        in_data      = '0;
        in_last      = 1'b0;
        in_padbytes  = '0;
        cfg_wr_en    = 1'b0;
        cfg_wr_idx   = '0;
        cfg_wr_port  = '0;
        cfg_wr_x     = '0;
        cfg_wr_y     = '0;
        cfg_wr_fbits = '0;
        noc_credit   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        assert (!in_hdr_rdy && !in_data_rdy && !noc_val)
            else abort_run("a ready or noc_val was high during reset");
        rst = 1'b0;
        write_table();
        for (int p = 0; p < NUM_PKTS; p++) begin
            send_packet(p);
        end
        for (int i = 0; (i < DRAIN_CYCLES) && (exp_q.size() != 0); i++) begin
            @(posedge clk);
        end
        repeat (40) @(posedge clk); // leave room for a stray flit to show up.
        if (exp_q.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run("expected flits never left the tile after the last packet");
        end
    end
endmodule

// ==== source/udp_pkt_if.sv ====
`timescale 1ns/1ns

interface udp_pkt_if;
    logic                   hdr_val;
    logic                   hdr_rdy;
    udp_rx_pkg::ip_addr_t   src_ip;
    udp_rx_pkg::ip_addr_t   dst_ip;
    udp_rx_pkg::udp_port_t  src_port;
    udp_rx_pkg::udp_port_t  dst_port;
    udp_rx_pkg::udp_len_t   length;
    udp_rx_pkg::timestamp_t timestamp;

    logic                   data_val;
    logic                   data_rdy;
    udp_rx_pkg::noc_flit_t  data;
    logic                   last;
    udp_rx_pkg::padbytes_t  padbytes;

    modport src (output hdr_val, src_ip, dst_ip, src_port, dst_port, length, timestamp,
                 output data_val, data, last, padbytes, input hdr_rdy, data_rdy);
    modport ctrl (input hdr_val, data_val, last, output hdr_rdy, data_rdy);
    modport datap (input src_ip, dst_ip, src_port, dst_port, length, timestamp,
                   input data, last, padbytes);
endinterface

// ==== source/udp_rx_consts.svh ====
`ifndef UDP_RX_CONSTS_SVH
`define UDP_RX_CONSTS_SVH

// flit and beat geometry.
`define NOC_DATA_W          128
`define NOC_DATA_BYTES_W    4
`define PADBYTES_W          4

// UDP and IP header fields.
`define IP_ADDR_W           32
`define PORT_W              16
`define UDP_LEN_W           16
`define TIMESTAMP_W         16
`define UDP_HDR_BYTES       8

// NoC header fields.
`define XY_W                8
`define FBITS_W             4
`define MSG_LEN_W           8
`define PKT_IF_FBITS        4'b1000
`define UDP_RX_SEGMENT      8'h12

// port table, credits and input buffering.
`define CAM_ENTRIES         8
`define CAM_IDX_W           3
`define NOC_CREDITS         4
`define CREDIT_W            3
`define IN_FIFO_DEPTH       4

`endif

// ==== source/udp_rx_in_buf.sv ====
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module udp_rx_in_buf (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_hdr_val,
    output logic                   in_hdr_rdy,
    input  udp_rx_pkg::ip_addr_t   in_src_ip,
    input  udp_rx_pkg::ip_addr_t   in_dst_ip,
    input  udp_rx_pkg::udp_port_t  in_src_port,
    input  udp_rx_pkg::udp_port_t  in_dst_port,
    input  udp_rx_pkg::udp_len_t   in_length,
    input  udp_rx_pkg::timestamp_t in_timestamp,
    input  logic                   in_data_val,
    output logic                   in_data_rdy,
    input  udp_rx_pkg::noc_flit_t  in_data,
    input  logic                   in_last,
    input  udp_rx_pkg::padbytes_t  in_padbytes,
    udp_pkt_if.src                 pkt
);
    localparam int PTR_W = $clog2(`IN_FIFO_DEPTH);

    logic                   running;
    logic                   hdr_full;
    logic                   hdr_load;
    logic                   push;
    logic                   pop;
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         fifo_cnt;

    udp_rx_pkg::noc_flit_t  fifo_data [`IN_FIFO_DEPTH];
    logic                   fifo_last [`IN_FIFO_DEPTH];
    udp_rx_pkg::padbytes_t  fifo_pad  [`IN_FIFO_DEPTH];

    assign in_hdr_rdy  = running && !hdr_full;
    assign in_data_rdy = running && (fifo_cnt != `IN_FIFO_DEPTH);
    assign hdr_load    = in_hdr_val && in_hdr_rdy;
    assign push        = in_data_val && in_data_rdy;
    assign pop         = pkt.data_val && pkt.data_rdy;

    assign pkt.hdr_val  = hdr_full;
    assign pkt.data_val = fifo_cnt != '0;
    assign pkt.data     = fifo_data[rd_ptr];
    assign pkt.last     = fifo_last[rd_ptr];
    assign pkt.padbytes = fifo_pad[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0; // inputs stay closed until the first cycle out of reset.
            hdr_full <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            running <= 1'b1;
            if (hdr_load) begin
                hdr_full <= 1'b1;
            end else if (pkt.hdr_val && pkt.hdr_rdy) begin
                hdr_full <= 1'b0;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            pkt.src_ip    <= in_src_ip;
            pkt.dst_ip    <= in_dst_ip;
            pkt.src_port  <= in_src_port;
            pkt.dst_port  <= in_dst_port;
            pkt.length    <= in_length;
            pkt.timestamp <= in_timestamp;
        end
        if (push) begin
            fifo_data[wr_ptr] <= in_data;
            fifo_last[wr_ptr] <= in_last;
            fifo_pad[wr_ptr]  <= in_padbytes;
        end
    end
endmodule

// ==== source/udp_rx_noc_out_ctrl.sv ====
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module udp_rx_noc_out_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    udp_pkt_if.ctrl                 pkt,
    input  logic                    cam_hit,
    input  logic                    no_data,
    output udp_rx_pkg::flit_sel_e   flit_sel,
    output logic                    store_inputs,
    output logic                    noc_val,
    input  logic                    noc_credit
);
    udp_rx_pkg::noc_out_state_e state;
    udp_rx_pkg::noc_out_state_e state_next;
    udp_rx_pkg::credit_cnt_t    credit_cnt;
    logic                       have_credit;

    assign have_credit = credit_cnt != '0;

    always_comb begin
        state_next   = state;
        store_inputs = 1'b0;
        pkt.hdr_rdy  = 1'b0;
        pkt.data_rdy = 1'b0;
        noc_val      = 1'b0;
        flit_sel     = udp_rx_pkg::SEL_DATA;
        case (state)
            udp_rx_pkg::IDLE: begin
                if (pkt.hdr_val) begin
                    store_inputs = 1'b1;
                    pkt.hdr_rdy  = 1'b1;
                    state_next   = udp_rx_pkg::HDR_FLIT;
                end
            end
            udp_rx_pkg::HDR_FLIT: begin
                flit_sel = udp_rx_pkg::SEL_HDR;
                if (!cam_hit) begin
                    state_next = no_data ? udp_rx_pkg::IDLE : udp_rx_pkg::DROP;
                end else if (have_credit) begin
                    noc_val    = 1'b1;
                    state_next = udp_rx_pkg::META_FLIT;
                end
            end
            udp_rx_pkg::META_FLIT: begin
                flit_sel = udp_rx_pkg::SEL_META;
                if (have_credit) begin
                    noc_val    = 1'b1;
                    state_next = no_data ? udp_rx_pkg::IDLE : udp_rx_pkg::DATA_FLIT;
                end
            end
            udp_rx_pkg::DATA_FLIT: begin
                if (have_credit && pkt.data_val) begin
                    noc_val      = 1'b1;
                    pkt.data_rdy = 1'b1;
                    if (pkt.last) begin
                        state_next = udp_rx_pkg::IDLE;
                    end
                end
            end
            udp_rx_pkg::DROP: begin
                pkt.data_rdy = 1'b1; // beats of an unknown port are thrown away.
                if (pkt.data_val && pkt.last) begin
                    state_next = udp_rx_pkg::IDLE;
                end
            end
            default: begin
                state_next = udp_rx_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= udp_rx_pkg::IDLE;
            credit_cnt <= udp_rx_pkg::credit_cnt_t'(`NOC_CREDITS);
        end else begin
            state <= state_next;
            case ({noc_val, noc_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt; // a send and a return cancel out.
            endcase
        end
    end
endmodule

// ==== source/udp_rx_noc_out_datap.sv ====
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module udp_rx_noc_out_datap #(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    udp_pkt_if.datap                pkt,
    input  logic                    store_inputs,
    input  udp_rx_pkg::flit_sel_e   flit_sel,
    output udp_rx_pkg::udp_port_t   cam_rd_tag,
    input  udp_rx_pkg::xy_coord_t   cam_x,
    input  udp_rx_pkg::xy_coord_t   cam_y,
    input  udp_rx_pkg::fbits_t      cam_fbits,
    output logic                    no_data,
    output udp_rx_pkg::noc_flit_t   noc_data
);
    localparam int HDR_FIELDS_W = 64;
    localparam int BYTES = `NOC_DATA_W / 8;

    udp_rx_pkg::ip_addr_t   src_ip_r;
    udp_rx_pkg::ip_addr_t   dst_ip_r;
    udp_rx_pkg::udp_port_t  src_port_r;
    udp_rx_pkg::udp_port_t  dst_port_r;
    udp_rx_pkg::udp_len_t   length_r;
    udp_rx_pkg::timestamp_t timestamp_r;

    udp_rx_pkg::udp_len_t   data_length;
    udp_rx_pkg::udp_len_t   data_flits;
    udp_rx_pkg::msg_len_t   msg_len;
    udp_rx_pkg::noc_flit_t  hdr_flit;
    udp_rx_pkg::noc_flit_t  meta_flit;
    udp_rx_pkg::noc_flit_t  masked_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            src_ip_r    <= '0;
            dst_ip_r    <= '0;
            src_port_r  <= '0;
            dst_port_r  <= '0;
            length_r    <= udp_rx_pkg::udp_len_t'(`UDP_HDR_BYTES);
            timestamp_r <= '0;
        end else if (store_inputs) begin
            src_ip_r    <= pkt.src_ip;
            dst_ip_r    <= pkt.dst_ip;
            src_port_r  <= pkt.src_port;
            dst_port_r  <= pkt.dst_port;
            length_r    <= pkt.length;
            timestamp_r <= pkt.timestamp;
        end
    end

    // the record is looked up in the cycle it is taken and while it is held.
    assign cam_rd_tag = store_inputs ? pkt.dst_port : dst_port_r;

    assign data_length = length_r - udp_rx_pkg::udp_len_t'(`UDP_HDR_BYTES);
    assign no_data     = data_length == '0;
    assign data_flits  = (data_length >> `NOC_DATA_BYTES_W)
                       + udp_rx_pkg::udp_len_t'(|data_length[`NOC_DATA_BYTES_W-1:0]);
    assign msg_len     = udp_rx_pkg::msg_len_t'(data_flits + 1'b1); // metadata plus data.

    assign hdr_flit = {{(`NOC_DATA_W - HDR_FIELDS_W){1'b0}},
                       cam_x,
                       cam_y,
                       cam_fbits,
                       msg_len,
                       udp_rx_pkg::xy_coord_t'(SRC_X),
                       udp_rx_pkg::xy_coord_t'(SRC_Y),
                       `PKT_IF_FBITS,
                       8'd1,
                       `UDP_RX_SEGMENT};

    assign meta_flit = {src_ip_r,
                        dst_ip_r,
                        src_port_r,
                        dst_port_r,
                        data_length,
                        timestamp_r};

    // pad bytes sit at the low end of the final beat.
    always_comb begin
        masked_data = pkt.data;
        for (int i = 0; i < BYTES; i++) begin
            if (pkt.last && (i < pkt.padbytes)) begin
                masked_data[i*8 +: 8] = 8'h00;
            end
        end
    end

    always_comb begin
        case (flit_sel)
            udp_rx_pkg::SEL_HDR:  noc_data = hdr_flit;
            udp_rx_pkg::SEL_META: noc_data = meta_flit;
            default:              noc_data = masked_data;
        endcase
    end
endmodule

// ==== source/udp_rx_pkg.sv ====
`include "udp_rx_consts.svh"

package udp_rx_pkg;

    typedef logic [`IP_ADDR_W-1:0]      ip_addr_t;
    typedef logic [`PORT_W-1:0]         udp_port_t;
    typedef logic [`UDP_LEN_W-1:0]      udp_len_t;
    typedef logic [`TIMESTAMP_W-1:0]    timestamp_t;
    typedef logic [`NOC_DATA_W-1:0]     noc_flit_t;
    typedef logic [`XY_W-1:0]           xy_coord_t;
    typedef logic [`FBITS_W-1:0]        fbits_t;
    typedef logic [`MSG_LEN_W-1:0]      msg_len_t;
    typedef logic [`PADBYTES_W-1:0]     padbytes_t;
    typedef logic [`CREDIT_W-1:0]       credit_cnt_t;

    // output stage sequencing.
    typedef enum logic [2:0] {
        IDLE,
        HDR_FLIT,
        META_FLIT,
        DATA_FLIT,
        DROP
    } noc_out_state_e;

    // which flit the datapath puts on the NoC.
    typedef enum logic [1:0] {
        SEL_HDR,
        SEL_META,
        SEL_DATA
    } flit_sel_e;

endpackage

// ==== source/udp_rx_port_cam.sv ====
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module udp_rx_port_cam (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_wr_en,
    input  logic [`CAM_IDX_W-1:0]   cfg_wr_idx,
    input  udp_rx_pkg::udp_port_t   cfg_wr_port,
    input  udp_rx_pkg::xy_coord_t   cfg_wr_x,
    input  udp_rx_pkg::xy_coord_t   cfg_wr_y,
    input  udp_rx_pkg::fbits_t      cfg_wr_fbits,
    input  udp_rx_pkg::udp_port_t   rd_tag,
    output logic                    rd_hit,
    output udp_rx_pkg::xy_coord_t   rd_x,
    output udp_rx_pkg::xy_coord_t   rd_y,
    output udp_rx_pkg::fbits_t      rd_fbits
);
    logic [`CAM_ENTRIES-1:0]    entry_val;
    udp_rx_pkg::udp_port_t      entry_port  [`CAM_ENTRIES];
    udp_rx_pkg::xy_coord_t      entry_x     [`CAM_ENTRIES];
    udp_rx_pkg::xy_coord_t      entry_y     [`CAM_ENTRIES];
    udp_rx_pkg::fbits_t         entry_fbits [`CAM_ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_val <= '0;
        end else if (cfg_wr_en) begin
            entry_val[cfg_wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr_en) begin
            entry_port[cfg_wr_idx]  <= cfg_wr_port;
            entry_x[cfg_wr_idx]     <= cfg_wr_x;
            entry_y[cfg_wr_idx]     <= cfg_wr_y;
            entry_fbits[cfg_wr_idx] <= cfg_wr_fbits;
        end
    end

    // Scanning from the top down lets the lowest matching index overwrite the rest.
    always_comb begin
        rd_hit   = 1'b0;
        rd_x     = '0;
        rd_y     = '0;
        rd_fbits = '0;
        for (int i = `CAM_ENTRIES - 1; i >= 0; i--) begin
            if (entry_val[i] && (entry_port[i] == rd_tag)) begin
                rd_hit   = 1'b1;
                rd_x     = entry_x[i];
                rd_y     = entry_y[i];
                rd_fbits = entry_fbits[i];
            end
        end
    end
endmodule

// ==== source/udp_rx_tile.sv ====
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module udp_rx_tile #(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_hdr_val,
    output logic                    in_hdr_rdy,
    input  udp_rx_pkg::ip_addr_t    in_src_ip,
    input  udp_rx_pkg::ip_addr_t    in_dst_ip,
    input  udp_rx_pkg::udp_port_t   in_src_port,
    input  udp_rx_pkg::udp_port_t   in_dst_port,
    input  udp_rx_pkg::udp_len_t    in_length,
    input  udp_rx_pkg::timestamp_t  in_timestamp,
    input  logic                    in_data_val,
    output logic                    in_data_rdy,
    input  udp_rx_pkg::noc_flit_t   in_data,
    input  logic                    in_last,
    input  udp_rx_pkg::padbytes_t   in_padbytes,
    input  logic                    cfg_wr_en,
    input  logic [`CAM_IDX_W-1:0]   cfg_wr_idx,
    input  udp_rx_pkg::udp_port_t   cfg_wr_port,
    input  udp_rx_pkg::xy_coord_t   cfg_wr_x,
    input  udp_rx_pkg::xy_coord_t   cfg_wr_y,
    input  udp_rx_pkg::fbits_t      cfg_wr_fbits,
    output logic                    noc_val,
    output udp_rx_pkg::noc_flit_t   noc_data,
    input  logic                    noc_credit
);
    udp_pkt_if pkt ();

    udp_rx_pkg::udp_port_t  cam_rd_tag;
    logic                   cam_hit;
    udp_rx_pkg::xy_coord_t  cam_x;
    udp_rx_pkg::xy_coord_t  cam_y;
    udp_rx_pkg::fbits_t     cam_fbits;
    udp_rx_pkg::flit_sel_e  flit_sel;
    logic                   store_inputs;
    logic                   no_data;

    udp_rx_in_buf u_in_buf (
        .clk          (clk),
        .rst          (rst),
        .in_hdr_val   (in_hdr_val),
        .in_hdr_rdy   (in_hdr_rdy),
        .in_src_ip    (in_src_ip),
        .in_dst_ip    (in_dst_ip),
        .in_src_port  (in_src_port),
        .in_dst_port  (in_dst_port),
        .in_length    (in_length),
        .in_timestamp (in_timestamp),
        .in_data_val  (in_data_val),
        .in_data_rdy  (in_data_rdy),
        .in_data      (in_data),
        .in_last      (in_last),
        .in_padbytes  (in_padbytes),
        .pkt          (pkt.src)
    );

    udp_rx_port_cam u_port_cam (
        .clk          (clk),
        .rst          (rst),
        .cfg_wr_en    (cfg_wr_en),
        .cfg_wr_idx   (cfg_wr_idx),
        .cfg_wr_port  (cfg_wr_port),
        .cfg_wr_x     (cfg_wr_x),
        .cfg_wr_y     (cfg_wr_y),
        .cfg_wr_fbits (cfg_wr_fbits),
        .rd_tag       (cam_rd_tag),
        .rd_hit       (cam_hit),
        .rd_x         (cam_x),
        .rd_y         (cam_y),
        .rd_fbits     (cam_fbits)
    );

    udp_rx_noc_out_ctrl u_noc_out_ctrl (
        .clk          (clk),
        .rst          (rst),
        .pkt          (pkt.ctrl),
        .cam_hit      (cam_hit),
        .no_data      (no_data),
        .flit_sel     (flit_sel),
        .store_inputs (store_inputs),
        .noc_val      (noc_val),
        .noc_credit   (noc_credit)
    );

    udp_rx_noc_out_datap #(
        .SRC_X (SRC_X),
        .SRC_Y (SRC_Y)
    ) u_noc_out_datap (
        .clk          (clk),
        .rst          (rst),
        .pkt          (pkt.datap),
        .store_inputs (store_inputs),
        .flit_sel     (flit_sel),
        .cam_rd_tag   (cam_rd_tag),
        .cam_x        (cam_x),
        .cam_y        (cam_y),
        .cam_fbits    (cam_fbits),
        .no_data      (no_data),
        .noc_data     (noc_data)
    );
endmodule

// ==== verilog.f ====
+incdir+source
source/udp_rx_pkg.sv
source/udp_pkt_if.sv
source/udp_rx_in_buf.sv
source/udp_rx_port_cam.sv
source/udp_rx_noc_out_ctrl.sv
source/udp_rx_noc_out_datap.sv
source/udp_rx_tile.sv
bench/clk_gen.sv
bench/udp_rx_tile_properties.sv
bench/udp_rx_tile_tb.sv
